// File: div_config.svh
`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// Operand and result width
`define DIV_WIDTH 32

// One restoring step per stage, so this equals DIV_WIDTH
`define DIV_STAGES 32

// Side information carried with each operation
`define DIV_TAG_WIDTH 8
`define DIV_PC_WIDTH 32
`define DIV_OP_WIDTH 4

`endif

// File: div_pkg.sv
`include "div_config.svh"

package div_pkg;

    // Operand, quotient or remainder
    typedef logic [`DIV_WIDTH-1:0] div_word_t;

    // Working word of the restoring divider.
    // Upper half holds the partial remainder, lower half starts as the
    // dividend and fills with quotient bits from the bottom.
    typedef logic [2*`DIV_WIDTH-1:0] div_work_t;

    // Physical register tag
    typedef logic [`DIV_TAG_WIDTH-1:0] div_tag_t;

    // Program counter of the issuing instruction
    typedef logic [`DIV_PC_WIDTH-1:0] div_pc_t;

    // Only DIVU selects the quotient
    typedef enum logic [`DIV_OP_WIDTH-1:0] {
        OP_DIVU = `DIV_OP_WIDTH'd1,
        OP_REMU = `DIV_OP_WIDTH'd2
    } div_op_t;

endpackage

// File: div_entry.sv
`timescale 1ns/1ps

module div_entry (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  div_pkg::div_word_t a,
    input  div_pkg::div_word_t b,
    input  div_pkg::div_tag_t  tag_in,
    input  div_pkg::div_pc_t   pc_in,
    input  div_pkg::div_op_t   op_in,
    output div_pkg::div_work_t work,
    output div_pkg::div_word_t divisor,
    output logic               valid,
    output logic               zero_div,
    output div_pkg::div_tag_t  tag,
    output div_pkg::div_pc_t   pc,
    output div_pkg::div_op_t   op
);
    import div_pkg::*;

    logic      b_zero;
    div_work_t work_d;

    assign b_zero = (b == '0);

    // Remainder starts at zero, dividend sits in the low half
    always_comb begin
        if (b_zero) begin
            work_d = '0;  // Nothing to divide, the result is forced to zero later
        end else begin
            work_d = {div_word_t'(0), a};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid    <= 1'b0;
            zero_div <= 1'b0;
        end else begin
            valid    <= start;
            zero_div <= start & b_zero;
        end
    end

    // Payload loads only on a started operation
    always_ff @(posedge clk) begin
        if (start) begin
            work    <= work_d;
            divisor <= b;  // Already zero when b_zero
            tag     <= tag_in;
            pc      <= pc_in;
            op      <= op_in;
        end
    end

endmodule

// File: div_stage.sv
`timescale 1ns/1ps

`include "div_config.svh"

module div_stage (
    input  logic               clk,
    input  logic               reset,
    input  div_pkg::div_work_t work_in,
    input  div_pkg::div_word_t divisor_in,
    output div_pkg::div_work_t work_out,
    output div_pkg::div_word_t divisor_out
);
    import div_pkg::*;

    logic [`DIV_WIDTH:0] rem_shift;
    logic [`DIV_WIDTH:0] rem_diff;
    logic                fits;
    div_word_t           rem_next;
    div_word_t           quo_next;

    // Shift left by one. The partial remainder can grow one bit past the
    // word, so it is kept 33 bits wide for the compare.
    assign rem_shift = work_in[2*`DIV_WIDTH-1:`DIV_WIDTH-1];
    assign rem_diff  = rem_shift - {1'b0, divisor_in};

    // Remainder stays below the divisor, so a clear borrow means it fits
    assign fits = ~rem_diff[`DIV_WIDTH];

    always_comb begin
        if (fits) begin
            rem_next = rem_diff[`DIV_WIDTH-1:0];
        end else begin
            rem_next = rem_shift[`DIV_WIDTH-1:0];  // Restore
        end
        quo_next = {work_in[`DIV_WIDTH-2:0], fits};  // New quotient bit at the bottom
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            work_out    <= '0;
            divisor_out <= '0;
        end else begin
            work_out    <= {rem_next, quo_next};
            divisor_out <= divisor_in;
        end
    end

endmodule

// File: div_tag_pipe.sv
`timescale 1ns/1ps

`include "div_config.svh"

module div_tag_pipe #(
    parameter int DEPTH = `DIV_STAGES
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              valid_in,
    input  logic              zero_div_in,
    input  div_pkg::div_op_t  op_in,
    input  div_pkg::div_tag_t tag_in,
    input  div_pkg::div_pc_t  pc_in,
    output logic              valid_out,
    output logic              zero_div_out,
    output div_pkg::div_op_t  op_out,
    output div_pkg::div_tag_t tag_out,
    output div_pkg::div_pc_t  pc_out
);
    import div_pkg::*;

    // Entry i is aligned with arithmetic stage i
    logic     valid_q [DEPTH];
    logic     zero_q  [DEPTH];
    div_op_t  op_q    [DEPTH];
    div_tag_t tag_q   [DEPTH];
    div_pc_t  pc_q    [DEPTH];

    // Control bits, flushed on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                valid_q[i] <= 1'b0;
                zero_q[i]  <= 1'b0;
            end
        end else begin
            valid_q[0] <= valid_in;
            zero_q[0]  <= zero_div_in;
            for (int i = 1; i < DEPTH; i++) begin
                valid_q[i] <= valid_q[i-1];
                zero_q[i]  <= zero_q[i-1];
            end
        end
    end

    // Side information just follows along
    always_ff @(posedge clk) begin
        op_q[0]  <= op_in;
        tag_q[0] <= tag_in;
        pc_q[0]  <= pc_in;
        for (int i = 1; i < DEPTH; i++) begin
            op_q[i]  <= op_q[i-1];
            tag_q[i] <= tag_q[i-1];
            pc_q[i]  <= pc_q[i-1];
        end
    end

    assign valid_out    = valid_q[DEPTH-1];
    assign zero_div_out = zero_q[DEPTH-1];
    assign op_out       = op_q[DEPTH-1];
    assign tag_out      = tag_q[DEPTH-1];
    assign pc_out       = pc_q[DEPTH-1];

endmodule

// File: div_retire.sv
`timescale 1ns/1ps

`include "div_config.svh"

module div_retire (
    input  logic               clk,
    input  logic               reset,
    input  div_pkg::div_work_t work,
    input  logic               valid,
    input  logic               zero_div,
    input  div_pkg::div_op_t   op,
    input  div_pkg::div_tag_t  tag_in,
    input  div_pkg::div_pc_t   pc_in,
    output div_pkg::div_word_t result,
    output logic               done,
    output logic               divide_zero_exception,
    output div_pkg::div_tag_t  tag_out,
    output div_pkg::div_pc_t   pc_out
);
    import div_pkg::*;

    div_word_t quotient;
    div_word_t remainder;
    div_word_t selected;

    // Final working word is remainder over quotient
    assign quotient  = work[`DIV_WIDTH-1:0];
    assign remainder = work[2*`DIV_WIDTH-1:`DIV_WIDTH];

    always_comb begin
        if (zero_div) begin
            selected = '0;
        end else if (op == OP_DIVU) begin
            selected = quotient;
        end else begin
            selected = remainder;  // REMU and any unused code
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            done                  <= 1'b0;
            divide_zero_exception <= 1'b0;
            result                <= '0;
            tag_out               <= '0;
            pc_out                <= '0;
        end else begin
            done                  <= valid;  // One cycle per operation
            divide_zero_exception <= valid & zero_div;
            if (valid) begin
                result  <= selected;
                tag_out <= tag_in;
                pc_out  <= pc_in;
            end
        end
    end

endmodule

// File: pipelined_divider.sv
`timescale 1ns/1ps

`include "div_config.svh"

module pipelined_divider (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  div_pkg::div_word_t a,
    input  div_pkg::div_word_t b,
    input  div_pkg::div_tag_t  tag_in,
    input  div_pkg::div_pc_t   pc_in,
    input  div_pkg::div_op_t   op_in,
    output div_pkg::div_word_t result,
    output logic               done,
    output logic               divide_zero_exception,
    output div_pkg::div_tag_t  tag_out,
    output div_pkg::div_pc_t   pc_out
);
    import div_pkg::*;

    // Element 0 comes from entry, element k+1 from stage k
    div_work_t work_chain    [`DIV_STAGES+1];
    div_word_t divisor_chain [`DIV_STAGES+1];

    logic      entry_valid;
    logic      entry_zero;
    div_tag_t  entry_tag;
    div_pc_t   entry_pc;
    div_op_t   entry_op;

    logic      pipe_valid;
    logic      pipe_zero;
    div_tag_t  pipe_tag;
    div_pc_t   pipe_pc;
    div_op_t   pipe_op;

    div_entry u_entry (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .a        (a),
        .b        (b),
        .tag_in   (tag_in),
        .pc_in    (pc_in),
        .op_in    (op_in),
        .work     (work_chain[0]),
        .divisor  (divisor_chain[0]),
        .valid    (entry_valid),
        .zero_div (entry_zero),
        .tag      (entry_tag),
        .pc       (entry_pc),
        .op       (entry_op)
    );

    // One quotient bit per stage, MSB first
    for (genvar k = 0; k < `DIV_STAGES; k++) begin : g_stage
        div_stage u_stage (
            .clk         (clk),
            .reset       (reset),
            .work_in     (work_chain[k]),
            .divisor_in  (divisor_chain[k]),
            .work_out    (work_chain[k+1]),
            .divisor_out (divisor_chain[k+1])
        );
    end

    div_tag_pipe #(
        .DEPTH (`DIV_STAGES)
    ) u_tag_pipe (
        .clk          (clk),
        .reset        (reset),
        .valid_in     (entry_valid),
        .zero_div_in  (entry_zero),
        .op_in        (entry_op),
        .tag_in       (entry_tag),
        .pc_in        (entry_pc),
        .valid_out    (pipe_valid),
        .zero_div_out (pipe_zero),
        .op_out       (pipe_op),
        .tag_out      (pipe_tag),
        .pc_out       (pipe_pc)
    );

    div_retire u_retire (
        .clk                   (clk),
        .reset                 (reset),
        .work                  (work_chain[`DIV_STAGES]),
        .valid                 (pipe_valid),
        .zero_div              (pipe_zero),
        .op                    (pipe_op),
        .tag_in                (pipe_tag),
        .pc_in                 (pipe_pc),
        .result                (result),
        .done                  (done),
        .divide_zero_exception (divide_zero_exception),
        .tag_out               (tag_out),
        .pc_out                (pc_out)
    );

endmodule

// File: pipelined_divider_properties.sv
`timescale 1ns/1ps

module pipelined_divider_properties (
    input logic               clk,
    input logic               reset,
    input logic               done,
    input logic               divide_zero_exception,
    input div_pkg::div_word_t result
);

    // Quiet outputs while reset is applied and one cycle after
    assert property (@(posedge clk)
        reset |=> !done && !divide_zero_exception)
        else $error("done or exception high during or right after reset");

    // Exception only comes with a completed operation
    assert property (@(posedge clk) disable iff (reset)
        divide_zero_exception |-> done)
        else $error("divide by zero exception without done");

    assert property (@(posedge clk) disable iff (reset)
        divide_zero_exception |-> result == '0)
        else $error("nonzero result on divide by zero");

endmodule

bind pipelined_divider pipelined_divider_properties u_props (
    .clk                   (clk),
    .reset                 (reset),
    .done                  (done),
    .divide_zero_exception (divide_zero_exception),
    .result                (result)
);

// File: tb_pipelined_divider.sv
`timescale 1ns/1ps

module tb_pipelined_divider;
    import div_pkg::*;

    localparam int LATENCY     = 33;
    localparam int DRAIN_LIMIT = 60;

    typedef struct packed {
        div_word_t result;
        logic      dz;
        div_tag_t  tag;
        div_pc_t   pc;
        int        issue_edge;
    } exp_entry_t;

    logic      clk;
    logic      reset;
    logic      start;
    div_word_t a;
    div_word_t b;
    div_tag_t  tag_in;
    div_pc_t   pc_in;
    div_op_t   op_in;
    div_word_t result;
    logic      done;
    logic      divide_zero_exception;
    div_tag_t  tag_out;
    div_pc_t   pc_out;

    exp_entry_t exp_q[$];
    string      name_q[$];
    int         edge_count;
    int         next_tag;

    pipelined_divider u_dut (
        .clk                   (clk),
        .reset                 (reset),
        .start                 (start),
        .a                     (a),
        .b                     (b),
        .tag_in                (tag_in),
        .pc_in                 (pc_in),
        .op_in                 (op_in),
        .result                (result),
        .done                  (done),
        .divide_zero_exception (divide_zero_exception),
        .tag_out               (tag_out),
        .pc_out                (pc_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    // Expected value straight from the divide rules
    function automatic div_word_t ref_result(div_word_t x, div_word_t y, div_op_t code);
        if (y == '0) begin
            return '0;
        end else if (code == OP_DIVU) begin
            return x / y;
        end else begin
            return x % y;
        end
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("mismatch %s expected %h actual %h", what, expected, actual));
        end
    endtask

    // Called 1 ns after a rising edge, returns 1 ns after the next one
    task automatic issue_op(input string name, input div_word_t op_a, input div_word_t op_b,
                            input div_op_t code, input div_tag_t tag, input div_pc_t pc);
        exp_entry_t e;
        e.result     = ref_result(op_a, op_b, code);
        e.dz         = (op_b == '0);
        e.tag        = tag;
        e.pc         = pc;
        e.issue_edge = edge_count + 1;
        start  = 1'b1;
        a      = op_a;
        b      = op_b;
        op_in  = code;
        tag_in = tag;
        pc_in  = pc;
        exp_q.push_back(e);
        name_q.push_back(name);
        @(posedge clk);
        #1;
    endtask

    task automatic issue_directed(input string name, input div_word_t op_a,
                                  input div_word_t op_b, input div_op_t code);
        div_pc_t pc;
        pc       = 32'h0000_1000 + 32'(next_tag) * 4;
        issue_op(name, op_a, op_b, code, div_tag_t'(next_tag), pc);
        next_tag = next_tag + 1;
    endtask

    task automatic issue_random(input string name);
        div_word_t x;
        div_word_t y;
        div_op_t   code;
        int        pick;
        x    = $urandom >> $urandom_range(0, 31);
        y    = $urandom >> $urandom_range(0, 31);
        if ($urandom_range(0, 15) == 0) begin
            y = '0;  // Occasional divide by zero
        end
        pick = $urandom_range(0, 4);
        if (pick < 2) begin
            code = OP_DIVU;
        end else if (pick < 4) begin
            code = OP_REMU;
        end else begin
            code = div_op_t'(4'($urandom_range(0, 15)));
        end
        issue_op(name, x, y, code, div_tag_t'($urandom), div_pc_t'($urandom));
    endtask

    task automatic idle(input int cycles);
        start = 1'b0;
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_drain(input string name);
        int waited;
        waited = 0;
        start  = 1'b0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_q.size() != 0) begin
            fail_run($sformatf("%s timed out with %0d results still missing", name,
                               exp_q.size()));
        end
    endtask

    // In-flight work is flushed, so nothing is expected back
    task automatic apply_reset();
        start = 1'b0;
        reset = 1'b1;
        @(posedge clk);
        #1;
        exp_q.delete();
        name_q.delete();
        repeat (2) begin
            @(posedge clk);
            #1;
        end
        reset = 1'b0;
    endtask

    initial begin : compare
        exp_entry_t e;
        string      name;
        forever begin
            @(negedge clk);
            if (done === 1'b1) begin
                if (exp_q.size() == 0) begin
                    fail_run("done pulse without a matching issued operation");
                end else begin
                    e    = exp_q.pop_front();
                    name = name_q.pop_front();
                    check_value({name, " result"}, e.result, result);
                    check_value({name, " exception"}, 32'(e.dz), 32'(divide_zero_exception));
                    check_value({name, " tag"}, 32'(e.tag), 32'(tag_out));
                    check_value({name, " pc"}, e.pc, pc_out);
                    check_value({name, " latency"}, LATENCY, 32'(edge_count - e.issue_edge));
                end
            end
        end
    end

    initial begin : stimulus
        int waited;
        void'($urandom(32'hf394_e8d5));
        edge_count = 0;
        next_tag   = 1;
        reset      = 1'b1;
        start      = 1'b0;
        a          = '0;
        b          = '0;
        tag_in     = '0;
        pc_in      = '0;
        op_in      = OP_DIVU;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        idle(2);

        issue_directed("divu_basic", 32'd100, 32'd7, OP_DIVU);
        issue_directed("divu_a_below_b", 32'd3, 32'd7, OP_DIVU);
        issue_directed("divu_a_equals_b", 32'd9, 32'd9, OP_DIVU);
        issue_directed("divu_by_one", 32'h1234_5678, 32'd1, OP_DIVU);
        issue_directed("divu_ones_by_ones", 32'hffff_ffff, 32'hffff_ffff, OP_DIVU);
        issue_directed("divu_ones_by_two", 32'hffff_ffff, 32'd2, OP_DIVU);
        issue_directed("divu_msb_by_three", 32'h8000_0000, 32'd3, OP_DIVU);
        wait_drain("directed quotients");

        issue_directed("remu_basic", 32'd100, 32'd7, OP_REMU);
        issue_directed("remu_a_below_b", 32'd3, 32'd7, OP_REMU);
        issue_directed("remu_a_equals_b", 32'd9, 32'd9, OP_REMU);
        issue_directed("remu_ones_by_two", 32'hffff_ffff, 32'd2, OP_REMU);
        issue_directed("rem_op_zero", 32'hdead_beef, 32'd1000, div_op_t'(4'd0));
        issue_directed("rem_op_fifteen", 32'hdead_beef, 32'h0001_0001, div_op_t'(4'd15));
        wait_drain("directed remainders");

        issue_directed("divzero_nonzero_a", 32'd123, 32'd0, OP_DIVU);
        issue_directed("divzero_zero_a", 32'd0, 32'd0, OP_REMU);
        issue_directed("divzero_unused_op", 32'hffff_ffff, 32'd0, div_op_t'(4'd7));
        wait_drain("divide by zero");

        repeat (300) begin
            issue_random("random_back_to_back");
        end
        wait_drain("random back to back");

        repeat (150) begin
            issue_random("random_gaps");
            idle($urandom_range(0, 3));
        end
        wait_drain("random gaps");

        repeat (20) begin
            issue_random("flushed_stream");
        end
        apply_reset();
        idle(40);  // Any done here would be a flushed operation
        repeat (10) begin
            issue_random("after_reset");
        end

        // Last operations must all come back before the limit
        start  = 1'b0;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end

        if (exp_q.size() != 0) begin
            fail_run($sformatf("%0d results still outstanding at end of run", exp_q.size()));
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

// File: compile.f
+incdir+.
div_pkg.sv
div_entry.sv
div_stage.sv
div_tag_pipe.sv
div_retire.sv
pipelined_divider.sv
pipelined_divider_properties.sv
tb_pipelined_divider.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_pipelined_divider \
    --Mdir obj_dir -o tb_sim \
    -f compile.f

./obj_dir/tb_sim 2>&1 | tee sim.log

if grep -q "TB PASSED" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
